/* sim.f */
+incdir+source
source/gpc4t_pkg.sv
source/threadSlotCounter.sv
source/pcBank.sv
source/instDecoder.sv
source/threadRegFile.sv
source/executeUnit.sv
source/core4t.sv
dv/core4tTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module core4tTb -Mdir obj_dir -o core4tSim \
    || exit 1
./obj_dir/core4tSim | tee /dev/stderr | grep -q "Result: PASSED" && exit 0 || exit 1

/* dv/core4tTb.sv */
// Testbench for the barrel core, builds per-thread programs, models memories and checks the bus
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module core4tTb
    import gpc4t_pkg::*;
();

    localparam int MemWords = 1024;  // 4 KB each for code and data
    localparam tRegPtr X0 = 5'd0, X1 = 5'd1, X2 = 5'd2, X3 = 5'd3;
    localparam tRegPtr X4 = 5'd4, X5 = 5'd5, X6 = 5'd6, X8 = 5'd8;

    logic    QClk = 1'b0;
    logic    reset = 1'b1;
    tAddr    pc;
    tWord    inst = '0;
    tDataReq dataReq;
    tWord    memRdData = '0;

    tWord    imem [MemWords];
    tWord    dmem [MemWords];
    tAddr    fetchAddr = '0;   // Registered fetch address
    tDataReq reqHeld = '0;     // Registered data request

    // Program builder and reference model
    logic [31:0] lfsr = 32'hb7c2;
    tAddr cur [`GPC_THREADS];       // Next free code address
    int   storeCnt [`GPC_THREADS];
    tWord regs [`GPC_THREADS][32];
    tWord refMem [MemWords];
    tAddr loopPc [`GPC_THREADS];    // Final self loop
    tAddr expPc [`GPC_THREADS][$];  // Fetch order of each thread
    tAddr expStAddr [`GPC_THREADS][$];
    tWord expStData [`GPC_THREADS][$];
    tAddr expLdAddr [`GPC_THREADS][$];
    int   storesLeft = -1;
    int   limitCycles = 0;
    int   cyc = 0;                  // Cycles since reset fell

    core4t u_core4t (.QClk, .reset, .pc, .inst, .dataReq, .memRdData);

    always #5 QClk = ~QClk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic tWord sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I instruction formats
    function automatic tWord encR(input logic [6:0] f7, input tRegPtr rs2, input tRegPtr rs1,
                                  input logic [2:0] f3, input tRegPtr rd);
        return {f7, rs2, rs1, f3, rd, `GPC_OP_OP};
    endfunction

    function automatic tWord encI(input logic [11:0] imm, input tRegPtr rs1,
                                  input logic [2:0] f3, input tRegPtr rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic tWord encS(input logic [11:0] imm, input tRegPtr rs2, input tRegPtr rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `GPC_OP_STORE};  // SW
    endfunction

    function automatic tWord encB(input logic [12:0] imm, input tRegPtr rs2, input tRegPtr rs1,
                                  input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `GPC_OP_BRANCH};
    endfunction

    function automatic tWord encU(input logic [19:0] imm, input tRegPtr rd, input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic tWord encJ(input logic [20:0] imm, input tRegPtr rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `GPC_OP_JAL};
    endfunction

    // Reference ALU per the RV32I spec, alt is funct7 bit 5
    function automatic tWord refAlu(input logic [2:0] f3, input logic alt, input tWord a,
                                    input tWord b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? tWord'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic refBranch(input logic [2:0] f3, input tWord a, input tWord b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////////////
    task automatic emit(input int t, input tWord w, input logic run);
        imem[cur[t][11:2]] = w;
        if (run) begin
            expPc[t].push_back(cur[t]);  // Skipped slots never fetch
        end
        cur[t] += 32'd4;
    endtask

    task automatic setReg(input int t, input tRegPtr rd, input tWord v);
        if (rd != X0) begin
            regs[t][rd] = v;
        end
    endtask

    task automatic loadConst(input int t, input tRegPtr rd, input tWord v);
        tWord hi;
        tWord lo;
        hi = (v + 32'h800) & 32'hffff_f000;  // Rounded so the low part fits ADDI
        lo = v - hi;
        emit(t, encU(hi[31:12], rd, `GPC_OP_LUI), 1'b1);
        emit(t, encI(lo[11:0], rd, 3'b000, rd, `GPC_OP_OPIMM), 1'b1);
        setReg(t, rd, v);
    endtask

    // Each thread stores into its own 256-byte window
    task automatic storeReg(input int t, input tRegPtr rs2);
        tAddr a;
        a = tAddr'(t * 256 + storeCnt[t] * 4);
        emit(t, encS(a[11:0], rs2, X0), 1'b1);
        expStAddr[t].push_back(a);
        expStData[t].push_back(regs[t][rs2]);
        refMem[a[11:2]] = regs[t][rs2];
        storeCnt[t]++;
    endtask

    task automatic doReg(input int t, input logic [2:0] f3, input logic alt);
        emit(t, encR(alt ? 7'h20 : 7'h00, X2, X1, f3, X3), 1'b1);
        setReg(t, X3, refAlu(f3, alt, regs[t][X1], regs[t][X2]));
        storeReg(t, X3);
    endtask

    task automatic doImm(input int t, input logic [2:0] f3, input logic alt,
                         input logic [11:0] imm);
        emit(t, encI(imm, X1, f3, X3, `GPC_OP_OPIMM), 1'b1);
        setReg(t, X3, refAlu(f3, alt, regs[t][X1], sext12(imm)));
        storeReg(t, X3);
    endtask

    task automatic buildThread(input int t);
        int     brF3 [6] = '{0, 1, 4, 5, 6, 7};
        tRegPtr pairA [3] = '{X1, X2, X1};
        tRegPtr pairB [3] = '{X2, X1, X1};  // Equal pair forces the other outcome
        logic [31:0] r;
        logic   taken;
        tAddr   here;
        cur[t] = `GPC_RESET_PC + tAddr'(t) * `GPC_THREAD_STRIDE;
        storeCnt[t] = 0;
        for (int i = 0; i < 32; i++) begin
            regs[t][i] = '0;
        end
        loadConst(t, X1, randBits(32));
        loadConst(t, X2, randBits(32));
        for (int f = 0; f < 8; f++) begin
            doReg(t, 3'(f), 1'b0);
            if (f == 0 || f == 5) begin
                doReg(t, 3'(f), 1'b1);  // SUB, SRA
            end
        end
        for (int f = 0; f < 8; f++) begin
            r = randBits(12);
            if (f == 1 || f == 5) begin
                doImm(t, 3'(f), 1'b0, {7'b0, r[4:0]});
                if (f == 5) begin
                    doImm(t, 3'(f), 1'b1, {7'b0100000, r[9:5]});  // SRAI
                end
            end else begin
                doImm(t, 3'(f), 1'b0, r[11:0]);
            end
        end
        r = randBits(20);
        emit(t, encU(r[19:0], X3, `GPC_OP_LUI), 1'b1);
        setReg(t, X3, {r[19:0], 12'b0});
        storeReg(t, X3);
        r = randBits(20);
        setReg(t, X3, cur[t] + {r[19:0], 12'b0});  // AUIPC adds its own PC
        emit(t, encU(r[19:0], X3, `GPC_OP_AUIPC), 1'b1);
        storeReg(t, X3);

        // Branches jump over one ADDI that counts the not-taken cases
        emit(t, encI(12'd0, X0, 3'b000, X5, `GPC_OP_OPIMM), 1'b1);
        setReg(t, X5, '0);
        for (int b = 0; b < 6; b++) begin
            for (int p = 0; p < 3; p++) begin
                taken = refBranch(3'(brF3[b]), regs[t][pairA[p]], regs[t][pairB[p]]);
                emit(t, encB(13'd8, pairB[p], pairA[p], 3'(brF3[b])), 1'b1);
                emit(t, encI(12'd1, X5, 3'b000, X5, `GPC_OP_OPIMM), !taken);
                if (!taken) begin
                    setReg(t, X5, regs[t][X5] + 32'd1);
                end
                storeReg(t, X5);
            end
        end

        here = cur[t];
        emit(t, encJ(21'd8, X4), 1'b1);  // JAL over one slot
        emit(t, encI(12'd1, X0, 3'b000, X4, `GPC_OP_OPIMM), 1'b0);
        setReg(t, X4, here + 32'd4);
        storeReg(t, X4);
        here = cur[t] + 32'd8;  // JALR address after the constant load
        loadConst(t, X6, here + 32'd6);  // Plus imm 3 gives an odd sum, bit 0 cleared
        emit(t, encI(12'd3, X6, 3'b000, X4, `GPC_OP_JALR), 1'b1);
        emit(t, encI(12'd1, X0, 3'b000, X4, `GPC_OP_OPIMM), 1'b0);
        setReg(t, X4, here + 32'd4);
        storeReg(t, X4);

        // Store, load back, modify, store again
        here = tAddr'(t * 256 + storeCnt[t] * 4);
        storeReg(t, X1);
        emit(t, encI(here[11:0], X0, 3'b010, X8, `GPC_OP_LOAD), 1'b1);
        expLdAddr[t].push_back(here);
        setReg(t, X8, refMem[here[11:2]]);
        r = randBits(12);
        emit(t, encI(r[11:0], X8, 3'b000, X8, `GPC_OP_OPIMM), 1'b1);
        setReg(t, X8, regs[t][X8] + sext12(r[11:0]));
        storeReg(t, X8);
        loopPc[t] = cur[t];
        emit(t, encJ(21'd0, X0), 1'b1);  // Park here
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory models, one cycle each way
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge QClk) begin
        fetchAddr = pc;
        reqHeld = dataReq;
    end

    always @(posedge QClk) begin
        #1;
        inst = imem[fetchAddr[11:2]];
        if (reqHeld.memWr) begin
            dmem[reqHeld.addr[11:2]] = reqHeld.wrData;
        end
        if (reqHeld.memRd) begin
            memRdData = dmem[reqHeld.addr[11:2]];
        end else begin
            memRdData = '0;  // Read data only follows a read request
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    quietInReset: assert property (@(posedge QClk) (dataReq.memRd || dataReq.memWr) |-> !reset)
        else failNow("memory request seen while reset was high");

    always @(negedge QClk) begin : monitor
        int   ft;
        int   st;
        tAddr wantPc;
        tAddr wantAddr;
        tWord wantData;
        if (reset) begin
            assert (!dataReq.memRd && !dataReq.memWr)
                else failNow("memory request raised during reset");
        end else begin
            ft = cyc % 4;  // Thread in Q100H
            wantPc = (expPc[ft].size() > 0) ? expPc[ft].pop_front() : loopPc[ft];
            if (cyc == 0) begin
                assert (pc == `GPC_RESET_PC)
                    else failNow($sformatf("mismatch pc after reset: got %h, expected %h",
                                           pc, `GPC_RESET_PC));
            end
            assert (pc == wantPc)
                else failNow($sformatf("mismatch pc thread %0d: got %h, expected %h",
                                       ft, pc, wantPc));
            if (cyc < 3) begin
                assert (!dataReq.memRd && !dataReq.memWr)
                    else failNow("memory request before the first instruction reached Q103H");
            end
            if (dataReq.memRd) begin
                st = (cyc + 1) % 4;  // Three stages behind the fetch slot
                assert (expLdAddr[st].size() > 0)
                    else failNow($sformatf("thread %0d loaded more often than its program", st));
                wantAddr = expLdAddr[st].pop_front();
                assert (dataReq.addr == wantAddr)
                    else failNow($sformatf("mismatch dataReq.addr thread %0d: got %h, expected %h",
                                           st, dataReq.addr, wantAddr));
            end
            if (dataReq.memWr) begin
                st = (cyc + 1) % 4;  // Three stages behind the fetch slot
                assert (expStAddr[st].size() > 0)
                    else failNow($sformatf("thread %0d stored more often than its program", st));
                wantAddr = expStAddr[st].pop_front();
                wantData = expStData[st].pop_front();
                assert (dataReq.addr == wantAddr)
                    else failNow($sformatf("mismatch dataReq.addr thread %0d: got %h, expected %h",
                                           st, dataReq.addr, wantAddr));
                assert (dataReq.wrData == wantData)
                    else failNow($sformatf("mismatch dataReq.wrData thread %0d: got %h, expected %h",
                                           st, dataReq.wrData, wantData));
                storesLeft--;
            end
            cyc++;
        end
    end

    // Watchdog
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge QClk);
        failNow("watchdog expired before every thread reached its final store");
    end

    initial begin
        int total;
        int longest;
        total = 0;
        longest = 0;
        for (int i = 0; i < MemWords; i++) begin
            dmem[i] = 32'hd000_0000 ^ (i * 32'h0001_0003);  // Whole index shows up
        end
        for (int t = 0; t < `GPC_THREADS; t++) begin
            buildThread(t);
            total += expStAddr[t].size();
            if (expPc[t].size() > longest) begin
                longest = expPc[t].size();
            end
        end
        storesLeft = total;
        limitCycles = 10 + longest * `GPC_THREADS + 64;
        repeat (10) @(posedge QClk);
        #1 reset = 1'b0;
        wait (storesLeft == 0);
        @(posedge QClk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* source/core4t.sv */
// Top of the four-thread barrel core, holds the stage registers and the memory ports
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module core4t
    import gpc4t_pkg::*;
(
    input  logic    QClk,
    input  logic    reset,
    output tAddr    pc,         // Q100H fetch address
    input  tWord    inst,       // Q101H, memory registered the PC
    output tDataReq dataReq,    // Q103H
    input  tWord    memRdData   // Q104H
);

    // Q103H and Q104H payload
    typedef struct packed {
        tWord   aluOut;
        tAddr   pcPlus4;   // Link value
        tWord   rs2Data;   // Store data
        tRegPtr rdPtr;
        logic   memRd;
        logic   memWr;
        logic   memToReg;
        logic   pcToReg;
        logic   regWr;
    } tLateStage;

    tThreadOh  threadQ100H, threadQ101H, threadQ102H, threadQ104H;
    tThreadOh  pcLoadQ102H;  // Valid-gated PC load mask
    logic      validQ101H, validQ102H, validQ103H, validQ104H;
    tAddr      pcQ101H;
    tDecoded   decodedQ101H;
    tRegPtr    rs1PtrQ101H, rs2PtrQ101H;
    tWord      rs1DataQ101H, rs2DataQ101H;
    tExecIn    execInQ102H;
    tWord      aluOutQ102H;
    tAddr      nextPcQ102H;
    tLateStage lateQ102H, lateQ103H, lateQ104H;
    tWriteBack writeBackQ104H;

    threadSlotCounter u_threadSlotCounter (.QClk, .reset, .threadQ100H, .threadQ101H,
                                           .threadQ102H, .threadQ104H);

    assign pcLoadQ102H = threadQ102H & {`GPC_THREADS{validQ102H}};  // No bubble updates a PC
    pcBank u_pcBank (.QClk, .reset, .threadQ100H, .threadQ102H(pcLoadQ102H),
                     .nextPc(nextPcQ102H), .pc);

    instDecoder u_instDecoder (.inst, .decoded(decodedQ101H), .rs1Ptr(rs1PtrQ101H),
                               .rs2Ptr(rs2PtrQ101H));

    threadRegFile u_threadRegFile (.QClk, .reset, .threadQ101H, .rs1Ptr(rs1PtrQ101H),
                                   .rs2Ptr(rs2PtrQ101H), .rs1Data(rs1DataQ101H),
                                   .rs2Data(rs2DataQ101H), .writeBack(writeBackQ104H));

    executeUnit u_executeUnit (.execIn(execInQ102H), .aluOut(aluOutQ102H),
                               .nextPc(nextPcQ102H));

    ////////////////////////////////////////////////////////////////////////////
    // Stage valids, first fetch after reset counts
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        if (reset) begin
            validQ101H <= 1'b0;
            validQ102H <= 1'b0;
            validQ103H <= 1'b0;
            validQ104H <= 1'b0;
        end else begin
            validQ101H <= 1'b1;
            validQ102H <= validQ101H;
            validQ103H <= validQ102H;
            validQ104H <= validQ103H;
        end
    end

    // Late stage payload from execute
    always_comb begin
        lateQ102H.aluOut   = aluOutQ102H;
        lateQ102H.pcPlus4  = execInQ102H.pc + tAddr'(4);
        lateQ102H.rs2Data  = execInQ102H.rs2Data;
        lateQ102H.rdPtr    = execInQ102H.dec.rdPtr;
        lateQ102H.memRd    = execInQ102H.dec.memRd;
        lateQ102H.memWr    = execInQ102H.dec.memWr;
        lateQ102H.memToReg = execInQ102H.dec.memToReg;
        lateQ102H.pcToReg  = execInQ102H.dec.pcToReg;
        lateQ102H.regWr    = execInQ102H.dec.regWr;
    end

    // Payload pipe
    always_ff @(posedge QClk) begin
        pcQ101H             <= pc;
        execInQ102H.pc      <= pcQ101H;
        execInQ102H.rs1Data <= rs1DataQ101H;
        execInQ102H.rs2Data <= rs2DataQ101H;
        execInQ102H.dec     <= decodedQ101H;
        lateQ103H           <= lateQ102H;
        lateQ104H           <= lateQ103H;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Q103H memory request, Q104H write back
    ////////////////////////////////////////////////////////////////////////////
    assign dataReq.memRd  = lateQ103H.memRd && validQ103H;
    assign dataReq.memWr  = lateQ103H.memWr && validQ103H;
    assign dataReq.addr   = lateQ103H.aluOut;
    assign dataReq.wrData = lateQ103H.rs2Data;

    always_comb begin
        writeBackQ104H.regWr  = lateQ104H.regWr && validQ104H;
        writeBackQ104H.thread = threadQ104H;
        writeBackQ104H.rdPtr  = lateQ104H.rdPtr;
        if (lateQ104H.memToReg) begin
            writeBackQ104H.data = memRdData;  // Load
        end else if (lateQ104H.pcToReg) begin
            writeBackQ104H.data = lateQ104H.pcPlus4;  // JAL/JALR link
        end else begin
            writeBackQ104H.data = lateQ104H.aluOut;
        end
    end

endmodule

/* source/executeUnit.sv */
// Q102H execute, operand select, shared ALU, branch comparator and next-PC choice
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module executeUnit
    import gpc4t_pkg::*;
(
    input  tExecIn execIn,
    output tWord   aluOut,
    output tAddr   nextPc
);

    localparam int ShamtW = $clog2(`GPC_XLEN);

    tDecoded           dec;
    tWord              aluIn1;
    tWord              aluIn2;
    logic [ShamtW-1:0] shamt;
    logic              branchTaken;

    assign dec = execIn.dec;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operands
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        aluIn1 = execIn.rs1Data;  // Register-register default, also branches
        aluIn2 = execIn.rs2Data;
        if (dec.lui) begin
            aluIn1 = '0;
            aluIn2 = dec.immU;
        end else if (dec.auiPc) begin
            aluIn1 = execIn.pc;
            aluIn2 = dec.immU;
        end else if (dec.iTypeImm) begin
            aluIn2 = dec.immI;
        end else if (dec.store) begin
            aluIn2 = dec.immS;  // Store address
        end
    end

    assign shamt = aluIn2[ShamtW-1:0];

    always_comb begin
        case (dec.aluOp)
            AluAdd:  aluOut = aluIn1 + aluIn2;
            AluSub:  aluOut = aluIn1 - aluIn2;
            AluSlt:  aluOut = tWord'($signed(aluIn1) < $signed(aluIn2));
            AluSltu: aluOut = tWord'(aluIn1 < aluIn2);
            AluSll:  aluOut = aluIn1 << shamt;
            AluSrl:  aluOut = aluIn1 >> shamt;
            AluSra:  aluOut = $signed(aluIn1) >>> shamt;
            AluXor:  aluOut = aluIn1 ^ aluIn2;
            AluOr:   aluOut = aluIn1 | aluIn2;
            AluAnd:  aluOut = aluIn1 & aluIn2;
            default: aluOut = '0;  // Illegal funct7/funct3 mix
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch comparator, always rs1 against rs2
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        branchTaken = 1'b0;
        if (dec.branch) begin
            case (dec.funct3)
                3'b000:  branchTaken = (execIn.rs1Data == execIn.rs2Data);  // BEQ
                3'b001:  branchTaken = (execIn.rs1Data != execIn.rs2Data);  // BNE
                3'b100:  branchTaken = $signed(execIn.rs1Data) < $signed(execIn.rs2Data);
                3'b101:  branchTaken = $signed(execIn.rs1Data) >= $signed(execIn.rs2Data);
                3'b110:  branchTaken = (execIn.rs1Data < execIn.rs2Data);   // BLTU
                3'b111:  branchTaken = (execIn.rs1Data >= execIn.rs2Data);  // BGEU
                default: branchTaken = 1'b0;
            endcase
        end
    end

    // Next PC, jumps and branches are PC relative except JALR
    always_comb begin
        if (dec.jalr) begin
            nextPc = {aluOut[`GPC_XLEN-1:1], 1'b0};
        end else if (dec.jal) begin
            nextPc = execIn.pc + dec.immJ;
        end else if (branchTaken) begin
            nextPc = execIn.pc + dec.immB;
        end else begin
            nextPc = execIn.pc + tAddr'(4);
        end
    end

endmodule

/* source/threadRegFile.sv */
// Four 32-entry register banks, one per thread, read at Q101H and written from Q104H
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module threadRegFile
    import gpc4t_pkg::*;
(
    input  logic      QClk,
    input  logic      reset,
    input  tThreadOh  threadQ101H,  // Bank for reads
    input  tRegPtr    rs1Ptr,
    input  tRegPtr    rs2Ptr,
    output tWord      rs1Data,
    output tWord      rs2Data,
    input  tWriteBack writeBack     // Carries its own thread mask
);

    localparam int RegCount = 1 << `GPC_REG_PTR_W;

    tWord bank [`GPC_THREADS][RegCount];

    // Write port, x0 stays zero
    always_ff @(posedge QClk) begin
        if (reset) begin
            for (int t = 0; t < `GPC_THREADS; t++) begin
                for (int r = 0; r < RegCount; r++) begin
                    bank[t][r] <= '0;
                end
            end
        end else if (writeBack.regWr && (writeBack.rdPtr != '0)) begin
            for (int t = 0; t < `GPC_THREADS; t++) begin
                if (writeBack.thread[t]) begin
                    bank[t][writeBack.rdPtr] <= writeBack.data;
                end
            end
        end
    end

    // Read ports
    // Write at end of Q104H is seen by the same thread's next Q101H, no bypass
    always_comb begin
        rs1Data = '0;
        rs2Data = '0;
        for (int t = 0; t < `GPC_THREADS; t++) begin
            if (threadQ101H[t]) begin
                rs1Data = bank[t][rs1Ptr];
                rs2Data = bank[t][rs2Ptr];
            end
        end
    end

endmodule

/* source/instDecoder.sv */
// Q101H decoder, splits the fetched word into register fields, immediates and control flags
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module instDecoder
    import gpc4t_pkg::*;
(
    input  tWord    inst,
    output tDecoded decoded,
    output tRegPtr  rs1Ptr,
    output tRegPtr  rs2Ptr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;    // SUB and SRA select
    logic       isOp;
    logic       isOpImm;
    logic       isShiftImm;  // SLLI, SRLI, SRAI

    ////////////////////////////////////////////////////////////////////////////
    // Field breakdown
    ////////////////////////////////////////////////////////////////////////////
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];
    assign rs1Ptr   = inst[19:15];  // R/I/S/B
    assign rs2Ptr   = inst[24:20];  // R/S/B

    assign isOp       = (opcode == `GPC_OP_OP);
    assign isOpImm    = (opcode == `GPC_OP_OPIMM);
    assign isShiftImm = isOpImm && (funct3[1:0] == 2'b01);

    ////////////////////////////////////////////////////////////////////////////
    // Immediates and controls
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        // Sign-extended immediates, all formats built every cycle
        decoded.immI = {{20{inst[31]}}, inst[31:20]};
        decoded.immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        decoded.immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        decoded.immU = {inst[31:12], 12'b0};
        decoded.immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

        decoded.funct3 = funct3;
        decoded.rdPtr  = inst[11:7];

        // Opcode class flags
        decoded.jal      = (opcode == `GPC_OP_JAL);
        decoded.jalr     = (opcode == `GPC_OP_JALR);
        decoded.branch   = (opcode == `GPC_OP_BRANCH);
        decoded.lui      = (opcode == `GPC_OP_LUI);
        decoded.auiPc    = (opcode == `GPC_OP_AUIPC);
        decoded.store    = (opcode == `GPC_OP_STORE);
        decoded.memRd    = (opcode == `GPC_OP_LOAD);   // Word loads only
        decoded.memWr    = (opcode == `GPC_OP_STORE);  // Word stores only
        decoded.memToReg = (opcode == `GPC_OP_LOAD);
        decoded.pcToReg  = decoded.jal || decoded.jalr;
        decoded.iTypeImm = isOpImm || decoded.memRd || decoded.jalr;
        decoded.regWr    = !(decoded.store || decoded.branch);

        // ALU op from funct3, funct7[5] only where it selects SUB/SRA
        if (isOp || isShiftImm) begin
            decoded.aluOp = tAluOp'({funct7b5, funct3});
        end else if (isOpImm) begin
            decoded.aluOp = tAluOp'({1'b0, funct3});  // ADDI with bit 30 set stays ADD
        end else begin
            decoded.aluOp = AluAdd;  // Address and LUI/AUIPC sums
        end
    end

endmodule

/* source/pcBank.sv */
// Per-thread program counters, loaded from execute at Q102H and muxed out for fetch at Q100H
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module pcBank
    import gpc4t_pkg::*;
(
    input  logic     QClk,
    input  logic     reset,
    input  tThreadOh threadQ100H,  // Fetching thread
    input  tThreadOh threadQ102H,  // Thread whose next PC is ready, valid-gated
    input  tAddr     nextPc,
    output tAddr     pc
);

    tAddr pcReg [`GPC_THREADS];

    // Each thread has its own start address
    always_ff @(posedge QClk) begin
        for (int t = 0; t < `GPC_THREADS; t++) begin
            if (reset) begin
                pcReg[t] <= tAddr'(`GPC_RESET_PC) + tAddr'(t) * tAddr'(`GPC_THREAD_STRIDE);
            end else if (threadQ102H[t]) begin
                pcReg[t] <= nextPc;  // Lands at end of Q102H
            end
        end
    end

    // AND-OR mux on the one-hot slot
    always_comb begin
        pc = '0;
        for (int t = 0; t < `GPC_THREADS; t++) begin
            pc = pc | ({`GPC_XLEN{threadQ100H[t]}} & pcReg[t]);
        end
    end

endmodule

/* source/threadSlotCounter.sv */
// One-hot thread slot rotator, gives the thread owning each pipe stage in the current cycle
`timescale 1ns/10ps
`include "gpc4t_params.svh"

module threadSlotCounter
    import gpc4t_pkg::*;
(
    input  logic     QClk,
    input  logic     reset,
    output tThreadOh threadQ100H,
    output tThreadOh threadQ101H,
    output tThreadOh threadQ102H,
    output tThreadOh threadQ104H
);

    tThreadOh slot;  // Thread now fetching

    // Thread 0 first after reset, then one step per cycle
    always_ff @(posedge QClk) begin
        if (reset) begin
            slot <= tThreadOh'(1);
        end else begin
            slot <= {slot[`GPC_THREADS-2:0], slot[`GPC_THREADS-1]};
        end
    end

    assign threadQ100H = slot;
    // Older stages hold the threads that fetched earlier, so rotate back
    assign threadQ101H = {threadQ100H[0], threadQ100H[`GPC_THREADS-1:1]};
    assign threadQ102H = {threadQ101H[0], threadQ101H[`GPC_THREADS-1:1]};
    assign threadQ104H = threadQ100H;  // Four stages back wraps to the fetching thread

endmodule

/* source/gpc4t_pkg.sv */
// Types shared by the barrel core modules, imported with a wildcard in each module header
`include "gpc4t_params.svh"

package gpc4t_pkg;

    typedef logic [`GPC_XLEN-1:0]      tWord;      // Data word
    typedef logic [`GPC_XLEN-1:0]      tAddr;      // Byte address
    typedef logic [`GPC_REG_PTR_W-1:0] tRegPtr;    // Register index
    typedef logic [`GPC_THREADS-1:0]   tThreadOh;  // One-hot thread mask

    // ALU op is {funct7[5], funct3}
    typedef enum logic [3:0] {
        AluAdd  = 4'b0000,
        AluSub  = 4'b1000,
        AluSll  = 4'b0001,
        AluSlt  = 4'b0010,
        AluSltu = 4'b0011,
        AluXor  = 4'b0100,
        AluSrl  = 4'b0101,
        AluSra  = 4'b1101,
        AluOr   = 4'b0110,
        AluAnd  = 4'b0111
    } tAluOp;

    // Decoder output, registered into Q102H
    typedef struct packed {
        tAluOp      aluOp;
        logic       jal;
        logic       jalr;
        logic       branch;
        logic       iTypeImm;   // OP-IMM, load, JALR
        logic       lui;
        logic       auiPc;
        logic       store;
        logic       memRd;
        logic       memWr;
        logic       memToReg;
        logic       pcToReg;    // Link value to rd
        logic       regWr;
        logic [2:0] funct3;     // Branch condition select
        tRegPtr     rdPtr;
        tWord       immI;
        tWord       immS;
        tWord       immB;
        tWord       immU;
        tWord       immJ;
    } tDecoded;

    // Q102H operands
    typedef struct packed {
        tAddr    pc;
        tWord    rs1Data;
        tWord    rs2Data;
        tDecoded dec;
    } tExecIn;

    // Data memory request, Q103H
    typedef struct packed {
        logic memRd;
        logic memWr;
        tAddr addr;
        tWord wrData;
    } tDataReq;

    // Register file write, Q104H
    typedef struct packed {
        logic     regWr;
        tThreadOh thread;
        tRegPtr   rdPtr;
        tWord     data;
    } tWriteBack;

endpackage

/* source/gpc4t_params.svh */
// Shared widths, thread count, reset addresses and RV32I opcodes, included by every RTL file
`ifndef GPC4T_PARAMS_SVH
`define GPC4T_PARAMS_SVH

// Datapath and thread geometry
`define GPC_XLEN            32
`define GPC_THREADS         4
`define GPC_REG_PTR_W       5

// Thread t starts at RESET_PC + t * THREAD_STRIDE
`define GPC_RESET_PC        32'h0000_0000
`define GPC_THREAD_STRIDE   32'h0000_0400

// RV32I major opcodes, inst[6:0]
`define GPC_OP_LUI          7'b0110111
`define GPC_OP_AUIPC        7'b0010111
`define GPC_OP_JAL          7'b1101111
`define GPC_OP_JALR         7'b1100111
`define GPC_OP_BRANCH       7'b1100011
`define GPC_OP_LOAD         7'b0000011
`define GPC_OP_STORE        7'b0100011
`define GPC_OP_OPIMM        7'b0010011
`define GPC_OP_OP           7'b0110011

`endif
